/* rtl/rvPkg.sv */
package rvPkg;

    // ================================================
    // widths with a meaning
    // ================================================
    typedef logic [31:0] wordT;     // data word or byte address
    typedef logic [31:0] instrT;    // raw instruction
    typedef logic [4:0]  regIdxT;   // architectural register index

    // ================================================
    // major opcodes of the supported subset
    // ================================================
    localparam logic [6:0] opR      = 7'd51;
    localparam logic [6:0] opImm    = 7'd19;
    localparam logic [6:0] opBranch = 7'd99;
    localparam logic [6:0] opJalr   = 7'd103;
    localparam logic [6:0] opJal    = 7'd111;
    localparam logic [6:0] opLoad   = 7'd3;
    localparam logic [6:0] opStore  = 7'd35;

    // ================================================
    // decode enums
    // ================================================
    typedef enum logic [2:0] {
        aluAdd = 3'b000,    // same code as funct3 of add
        aluSll = 3'b001,
        aluXor = 3'b100,
        aluSrl = 3'b101,
        aluAnd = 3'b111
    } aluOpT;

    typedef enum logic [1:0] {
        immI = 2'd0,        // addi, lw, jalr
        immS = 2'd1,        // sw
        immB = 2'd2,        // beq, bne
        immJ = 2'd3         // jal
    } immKindT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2   // link value of jumps
    } resultSrcT;

    typedef enum logic [1:0] {
        pcSeq    = 2'd0,    // pc + 4
        pcTarget = 2'd1,    // pc + imm
        pcAluRes = 2'd2     // rs1 + imm, bit 0 cleared
    } pcSrcT;

    typedef enum logic [1:0] {
        dpIdle = 2'd0,
        dpBus  = 2'd1,
        dpDone = 2'd2
    } dpStateT;

endpackage

/* rtl/controlUnit.sv */
module controlUnit import rvPkg::*; (
    input  logic [6:0] op,
    input  logic [2:0] funct3,
    input  logic       funct7,      // instruction bit 30
    input  logic       zero,
    output pcSrcT      pcSrc,
    output resultSrcT  resultSrc,
    output logic       memWrite,
    output logic       memRead,
    output aluOpT      aluOp,
    output logic       aluSrc,      // 1 selects the immediate
    output immKindT    immKind,
    output logic       regWrite
);

    always_comb begin
        // anything not matched below behaves as a no-op
        pcSrc     = pcSeq;
        resultSrc = resAlu;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        aluOp     = aluAdd;
        aluSrc    = 1'b0;
        immKind   = immI;
        regWrite  = 1'b0;

        case (op)
            // ================================================
            // arithmetic and control flow
            // ================================================
            opR: begin
                if (!funct7) begin                  // sub and sra not supported
                    case (funct3)
                        3'b000: begin               // add
                            aluOp    = aluAdd;
                            regWrite = 1'b1;
                        end
                        3'b001: begin               // sll
                            aluOp    = aluSll;
                            regWrite = 1'b1;
                        end
                        3'b100: begin               // xor
                            aluOp    = aluXor;
                            regWrite = 1'b1;
                        end
                        3'b101: begin               // srl
                            aluOp    = aluSrl;
                            regWrite = 1'b1;
                        end
                        3'b111: begin               // and
                            aluOp    = aluAnd;
                            regWrite = 1'b1;
                        end
                        default: ;                  // slt, sltu, or
                    endcase
                end
            end

            opImm: begin
                case (funct3)
                    3'b000: begin                   // addi
                        aluOp    = aluAdd;
                        aluSrc   = 1'b1;
                        immKind  = immI;
                        regWrite = 1'b1;
                    end
                    default: ;
                endcase
            end

            opBranch: begin
                case (funct3)
                    3'b000: begin                   // beq
                        aluOp   = aluXor;           // zero means equal
                        immKind = immB;
                        pcSrc   = zero ? pcTarget : pcSeq;
                    end
                    3'b001: begin                   // bne
                        aluOp   = aluXor;
                        immKind = immB;
                        pcSrc   = zero ? pcSeq : pcTarget;
                    end
                    default: ;
                endcase
            end

            opJalr: begin
                case (funct3)
                    3'b000: begin
                        pcSrc     = pcAluRes;       // rs1 + offset
                        resultSrc = resPcPlus4;
                        aluOp     = aluAdd;
                        aluSrc    = 1'b1;
                        immKind   = immI;
                        regWrite  = 1'b1;
                    end
                    default: ;
                endcase
            end

            opJal: begin
                pcSrc     = pcTarget;
                resultSrc = resPcPlus4;             // return address
                immKind   = immJ;
                regWrite  = 1'b1;
            end

            // ================================================
            // data memory
            // ================================================
            opLoad: begin
                case (funct3)
                    3'b010: begin                   // lw
                        memRead   = 1'b1;
                        resultSrc = resMem;
                        aluOp     = aluAdd;         // base + offset
                        aluSrc    = 1'b1;
                        immKind   = immI;
                        regWrite  = 1'b1;
                    end
                    default: ;
                endcase
            end

            opStore: begin
                case (funct3)
                    3'b010: begin                   // sw
                        memWrite = 1'b1;
                        aluOp    = aluAdd;
                        aluSrc   = 1'b1;
                        immKind  = immS;
                    end
                    default: ;
                endcase
            end

            default: ;
        endcase
    end

endmodule

/* rtl/aluUnit.sv */
module aluUnit import rvPkg::*; (
    input  wordT  a,
    input  wordT  b,
    input  aluOpT aluOp,
    output wordT  result,
    output logic  zero
);

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = a + b;
            end
            aluSll: begin
                result = a << b[4:0];           // shift amount is 5 bits
            end
            aluXor: begin
                result = a ^ b;                 // also the branch compare
            end
            aluSrl: begin
                result = a >> b[4:0];
            end
            aluAnd: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rtl/regFile.sv */
module regFile import rvPkg::*; #(
    parameter int NumRegs = 32          // 16 for the reduced file
) (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  logic   wrEn,
    input  wordT   wrData,
    output wordT   rd1,
    output wordT   rd2
);

    localparam int IdxW = $clog2(NumRegs);

    wordT regs [NumRegs];

    // indexes beyond the file read as zero
    assign rd1 = (int'(rs1) < NumRegs) ? regs[rs1[IdxW-1:0]] : '0;
    assign rd2 = (int'(rs2) < NumRegs) ? regs[rs2[IdxW-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rd != '0 && int'(rd) < NumRegs) begin
            regs[rd[IdxW-1:0]] <= wrData;   // x0 never written
        end
    end

endmodule

/* rtl/dataPort.sv */
module dataPort import rvPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic memRead,
    input  logic memWrite,
    input  wordT addr,
    input  wordT storeData,
    output logic memDone,
    output wordT loadData,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output wordT wbAdr,
    output wordT wbDatW,
    input  wordT wbDatR,
    input  logic wbAck
);

    dpStateT state;
    logic    busReq;                            // drives cyc and stb together

    assign wbCyc   = busReq;
    assign wbStb   = busReq;
    assign memDone = (state == dpDone);

    // ================================================
    // control state
    // ================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= dpIdle;
            busReq <= 1'b0;
            wbWe   <= 1'b0;
        end else begin
            case (state)
                dpIdle: begin
                    if (memRead || memWrite) begin
                        state  <= dpBus;
                        busReq <= 1'b1;
                        wbWe   <= memWrite;
                    end
                end
                dpBus: begin
                    if (wbAck) begin            // hold until the slave answers
                        state  <= dpDone;
                        busReq <= 1'b0;
                        wbWe   <= 1'b0;
                    end
                end
                default: begin
                    state <= dpIdle;            // one cycle of memDone
                end
            endcase
        end
    end

    // ================================================
    // payload
    // ================================================
    always_ff @(posedge clk) begin
        if (state == dpIdle) begin
            wbAdr  <= {addr[31:2], 2'b00};      // word aligned
            wbDatW <= storeData;
        end
        if (state == dpBus && wbAck) begin
            loadData <= wbDatR;
        end
    end

endmodule

/* rtl/rvCore.sv */
module rvCore import rvPkg::*; #(
    parameter wordT ResetPc = '0,
    parameter int   NumRegs = 32
) (
    input  logic  clk,
    input  logic  rstN,

    // instruction fetch, answered in the same cycle
    output wordT  imemAddr,
    input  instrT imemData,

    // wishbone classic data master
    output logic  wbCyc,
    output logic  wbStb,
    output logic  wbWe,
    output wordT  wbAdr,
    output wordT  wbDatW,
    input  wordT  wbDatR,
    input  logic  wbAck
);

    wordT      pc;
    wordT      pcNext;
    wordT      pcPlus4;
    wordT      branchTarget;
    wordT      imm;
    wordT      rd1;
    wordT      rd2;
    wordT      srcB;
    wordT      aluResult;
    wordT      loadData;
    wordT      wrData;
    logic      zero;
    logic      stall;
    logic      memDone;
    pcSrcT     pcSrc;
    resultSrcT resultSrc;
    logic      memWrite;
    logic      memRead;
    aluOpT     aluOp;
    logic      aluSrc;
    immKindT   immKind;
    logic      regWrite;

    assign imemAddr = pc;

    // ================================================
    // decode and immediate
    // ================================================
    controlUnit i_controlUnit (
        .op        (imemData[6:0]),
        .funct3    (imemData[14:12]),
        .funct7    (imemData[30]),
        .zero      (zero),
        .pcSrc     (pcSrc),
        .resultSrc (resultSrc),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .aluOp     (aluOp),
        .aluSrc    (aluSrc),
        .immKind   (immKind),
        .regWrite  (regWrite)
    );

    always_comb begin
        case (immKind)
            immS:    imm = {{20{imemData[31]}}, imemData[31:25], imemData[11:7]};
            immB:    imm = {{19{imemData[31]}}, imemData[31], imemData[7],
                            imemData[30:25], imemData[11:8], 1'b0};
            immJ:    imm = {{11{imemData[31]}}, imemData[31], imemData[19:12],
                            imemData[20], imemData[30:21], 1'b0};
            default: imm = {{20{imemData[31]}}, imemData[31:20]};
        endcase
    end

    // ================================================
    // datapath
    // ================================================
    regFile #(
        .NumRegs (NumRegs)
    ) i_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (imemData[19:15]),
        .rs2    (imemData[24:20]),
        .rd     (imemData[11:7]),
        .wrEn   (regWrite && !stall),           // frozen while waiting on the bus
        .wrData (wrData),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    assign srcB = aluSrc ? imm : rd2;

    aluUnit i_aluUnit (
        .a      (rd1),
        .b      (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    dataPort i_dataPort (
        .clk       (clk),
        .rstN      (rstN),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .addr      (aluResult),
        .storeData (rd2),
        .memDone   (memDone),
        .loadData  (loadData),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck)
    );

    always_comb begin
        case (resultSrc)
            resMem:     wrData = loadData;
            resPcPlus4: wrData = pcPlus4;       // link value
            default:    wrData = aluResult;
        endcase
    end

    // ================================================
    // program counter
    // ================================================
    assign stall        = (memRead || memWrite) && !memDone;
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm;

    always_comb begin
        case (pcSrc)
            pcTarget: pcNext = branchTarget;
            pcAluRes: pcNext = {aluResult[31:1], 1'b0};
            default:  pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

endmodule

/* bench/rvCoreTb.sv */
module rvCoreTb import rvPkg::*; ();

    logic  clk = 1'b0;
    logic  rstN;
    wordT  imemAddr;
    instrT imemData;
    logic  wbCyc;
    logic  wbStb;
    logic  wbWe;
    wordT  wbAdr;
    wordT  wbDatW;
    wordT  wbDatR;
    logic  wbAck;

    instrT prog [64];                       // instruction image, word indexed
    wordT  dmem [64];                       // slave memory
    wordT  refMem [64];                     // model copy of data memory
    wordT  expAddr [$];
    wordT  expData [$];
    wordT  finalPc;
    int    storeIdx = 0;
    int    dataErrors = 0;
    int    protoErrors = 0;
    int    timeoutErrors = 0;
    int    waitLeft = 0;
    logic  slaveBusy = 1'b0;
    logic  memSeen = 1'b0;
    logic  prevWait = 1'b0;
    logic  prevAck = 1'b0;
    logic  prevWe;
    wordT  prevAdr;
    wordT  prevDat;

    always #5 clk = ~clk;

    assign imemData = prog[imemAddr[7:2]];  // combinational fetch

    rvCore #(
        .ResetPc (32'h0),
        .NumRegs (32)
    ) i_rvCore (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatW   (wbDatW),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck)
    );

    // ==================================================
    // instruction encoders
    // ==================================================
    function automatic instrT encR(logic [2:0] f3, wordT rd, wordT rs1, wordT rs2);
        return {7'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], opR};
    endfunction

    function automatic instrT encI(logic [6:0] op, logic [2:0] f3, wordT rd, wordT rs1,
                                   wordT imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic instrT encS(wordT rs2, wordT rs1, wordT imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction

    function automatic instrT encB(logic [2:0] f3, wordT rs1, wordT rs2, wordT imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic instrT encJ(wordT rd, wordT imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    task automatic buildProgram();
        wordT rA;
        wordT rB;
        wordT rC;
        rA = $urandom & 32'hfff;
        rB = $urandom & 32'hfff;
        rC = $urandom & 32'hfff;            // low 5 bits give the shift amount
        for (int i = 0; i < 64; i++) begin
            prog[i] = encI(opImm, 3'd0, 0, 0, 0);
        end
        prog[0]  = encI(opImm, 3'd0, 1, 0, rA);
        prog[1]  = encI(opImm, 3'd0, 2, 0, rB);
        prog[2]  = encI(opImm, 3'd0, 3, 0, rC);
        prog[3]  = encI(opImm, 3'd0, 10, 0, 1);
        prog[4]  = encR(3'b000, 4, 1, 2);   // add
        prog[5]  = encS(4, 0, 128);
        prog[6]  = encR(3'b001, 5, 1, 3);   // sll
        prog[7]  = encS(5, 0, 132);
        prog[8]  = encR(3'b100, 6, 1, 2);   // xor
        prog[9]  = encS(6, 0, 136);
        prog[10] = encR(3'b101, 7, 1, 3);   // srl
        prog[11] = encS(7, 0, 140);
        prog[12] = encR(3'b111, 8, 1, 2);   // and
        prog[13] = encS(8, 0, 144);
        prog[14] = encS(1, 0, 148);         // addi result
        prog[15] = encI(opLoad, 3'd2, 9, 0, 8);
        prog[16] = encR(3'b000, 9, 9, 1);
        prog[17] = encS(9, 0, 152);         // load round trip
        prog[18] = encB(3'b000, 1, 1, 8);   // beq taken
        prog[19] = encS(1, 0, 156);
        prog[20] = encB(3'b000, 0, 10, 8);  // beq not taken
        prog[21] = encS(2, 0, 160);
        prog[22] = encB(3'b001, 0, 10, 8);  // bne taken
        prog[23] = encS(3, 0, 164);
        prog[24] = encB(3'b001, 1, 1, 8);   // bne not taken
        prog[25] = encS(10, 0, 168);
        prog[26] = encJ(11, 8);
        prog[27] = encS(1, 0, 172);
        prog[28] = encS(11, 0, 176);        // jal link
        prog[29] = encI(opImm, 3'd0, 13, 0, 125);
        prog[30] = encI(opJalr, 3'd0, 12, 13, 4);  // odd target, lands on 128
        prog[31] = encS(1, 0, 180);
        prog[32] = encS(12, 0, 184);        // jalr link
        prog[33] = encR(3'b011, 14, 1, 2);  // unsupported under opR
        prog[34] = encI(opImm, 3'd0, 0, 0, 77);
        prog[35] = encS(0, 0, 188);
        prog[36] = encS(14, 0, 192);
        prog[37] = encJ(0, 0);              // self loop
    endtask

    // ==================================================
    // instruction set model
    // ==================================================
    function automatic wordT modelProgram();
        wordT  x [32];
        wordT  pc;
        wordT  nextPc;
        wordT  a;
        wordT  b;
        wordT  ea;
        instrT ins;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < 500; step++) begin
            ins = prog[pc[7:2]];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            nextPc = pc + 4;
            case (ins[6:0])
                opR: begin
                    if (!ins[30]) begin
                        case (ins[14:12])
                            3'b000:  x[ins[11:7]] = a + b;
                            3'b001:  x[ins[11:7]] = a << b[4:0];
                            3'b100:  x[ins[11:7]] = a ^ b;
                            3'b101:  x[ins[11:7]] = a >> b[4:0];
                            3'b111:  x[ins[11:7]] = a & b;
                            default: ;
                        endcase
                    end
                end
                opImm: begin
                    if (ins[14:12] == 3'b000) x[ins[11:7]] = a + {{20{ins[31]}}, ins[31:20]};
                end
                opBranch: begin
                    ea = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    if (ins[14:12] == 3'b000 && a == b) nextPc = ea;
                    if (ins[14:12] == 3'b001 && a != b) nextPc = ea;
                end
                opJalr: begin
                    if (ins[14:12] == 3'b000) begin
                        nextPc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
                        x[ins[11:7]] = pc + 4;
                    end
                end
                opJal: begin
                    x[ins[11:7]] = pc + 4;
                    nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                opLoad: begin
                    ea = a + {{20{ins[31]}}, ins[31:20]};
                    if (ins[14:12] == 3'b010) x[ins[11:7]] = refMem[ea[7:2]];
                end
                opStore: begin
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (ins[14:12] == 3'b010) begin
                        refMem[ea[7:2]] = b;
                        expAddr.push_back({ea[31:2], 2'b00});
                        expData.push_back(b);
                    end
                end
                default: ;
            endcase
            x[0] = '0;
            if (nextPc == pc) return pc;
            pc = nextPc;
        end
        return pc;
    endfunction

    // ==================================================
    // wishbone slave and checkers
    // ==================================================
    always @(posedge clk) begin
        logic ackNow;
        wordT rdData;
        #1;                                         // zero wait states ack in the first cycle
        ackNow = 1'b0;
        rdData = '0;
        if (rstN && wbCyc && wbStb && !wbAck) begin
            if (!slaveBusy) begin
                slaveBusy = 1'b1;
                waitLeft = $urandom_range(3, 0);    // wait states for this request
            end
            if (waitLeft == 0) begin
                ackNow = 1'b1;
                slaveBusy = 1'b0;
                if (wbWe) dmem[wbAdr[7:2]] = wbDatW;
                else rdData = dmem[wbAdr[7:2]];
            end else begin
                waitLeft--;
            end
        end
        wbAck <= ackNow;
        wbDatR <= rdData;
    end

    always @(posedge clk) begin
        if (rstN && wbCyc && wbStb && wbAck && wbWe) begin
            if (storeIdx >= expAddr.size()) begin
                dataErrors++;
                $display("extra store to address %h that the model never made", wbAdr);
            end else begin
                if (wbAdr !== expAddr[storeIdx]) begin
                    dataErrors++;
                    $display("ERROR store %0d address: expected %h, actual %h",
                             storeIdx, expAddr[storeIdx], wbAdr);
                end
                if (wbDatW !== expData[storeIdx]) begin
                    dataErrors++;
                    $display("ERROR store %0d data: expected %h, actual %h",
                             storeIdx, expData[storeIdx], wbDatW);
                end
                storeIdx++;
            end
        end
    end

    always @(posedge clk) begin
        if ((!rstN || !memSeen) && (wbCyc || wbStb)) begin
            protoErrors++;
            $display("bus cycle active before the first memory instruction");
        end
        if (prevWait && (!wbStb || wbAdr !== prevAdr || wbWe !== prevWe
                         || wbDatW !== prevDat)) begin
            protoErrors++;
            $display("request changed or dropped while waiting for ack");
        end
        if (prevAck && (wbCyc || wbStb)) begin
            protoErrors++;
            $display("strobe still high in the cycle after ack");
        end
        prevWait = wbStb && !wbAck;
        prevAck = wbStb && wbAck;
        prevAdr = wbAdr;
        prevWe = wbWe;
        prevDat = wbDatW;
        if (rstN && (imemData[6:0] == opLoad || imemData[6:0] == opStore)) memSeen = 1'b1;
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int cycles;
        rstN = 1'b0;
        wbAck = 1'b0;
        wbDatR = '0;
        void'($urandom(93283));
        buildProgram();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom;
            refMem[i] = dmem[i];
        end
        finalPc = modelProgram();
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;

        cycles = 0;
        while (storeIdx < expAddr.size() && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (storeIdx < expAddr.size()) begin
            timeoutErrors++;
            $display("timed out waiting for stores, %0d of %0d seen", storeIdx, expAddr.size());
        end
        cycles = 0;
        while (imemAddr !== finalPc && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (imemAddr !== finalPc) begin
            dataErrors++;
            $display("ERROR final pc: expected %h, actual %h", finalPc, imemAddr);
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);                 // room for a stray store to show up
        end

        $display("errors: data %0d, protocol %0d, timeout %0d",
                 dataErrors, protoErrors, timeoutErrors);
        if (dataErrors + protoErrors + timeoutErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/rvPkg.sv
rtl/controlUnit.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/dataPort.sv
rtl/rvCore.sv
bench/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the rvCore testbench with Verilator, run it, and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module rvCoreTb -f project.f \
    -Mdir obj_dir -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rvCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation log has no result line"
    exit 1
fi

exit 0
